// ==== mips_defines.svh ====
// Global widths and fixed addresses for the MIPS core and its testbench, pulled in by `include
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Datapath
`define MIPS_WORD_W    32              // Data and address width
`define MIPS_REG_COUNT 32              // General purpose registers

// Program counter landmarks
`define MIPS_RESET_PC  32'hBFC00000    // Boot vector, first fetch
`define MIPS_HALT_PC   32'h00000000    // Landing here stops the core

`endif

// ==== mipsIsaPkg.sv ====
// Instruction-set types for the MIPS core; stages import it to split and carry instruction fields
`default_nettype none

`include "mips_defines.svh"

package mipsIsaPkg;

    typedef logic [`MIPS_WORD_W-1:0]             word_t;       // Data or address word
    typedef logic [$clog2(`MIPS_REG_COUNT)-1:0]  regAddr_t;    // Register number
    typedef logic [15:0]                         imm_t;        // I-type immediate
    typedef logic [25:0]                         jumpTarget_t; // J-type word index
    typedef logic [4:0]                          shamt_t;      // Shift amount

    // Primary opcode, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0,     // R-type, decoded by funct
        OP_J       = 6'd2,
        OP_BEQ     = 6'd4,
        OP_BNE     = 6'd5,
        OP_ADDIU   = 6'd9,
        OP_SLTI    = 6'd10,
        OP_SLTIU   = 6'd11,
        OP_ANDI    = 6'd12,
        OP_ORI     = 6'd13,
        OP_XORI    = 6'd14,
        OP_LUI     = 6'd15,
        OP_LW      = 6'd35,
        OP_SW      = 6'd43
    } opcode_t;

    // R-type function code, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

endpackage

`default_nettype wire

// ==== mipsCorePkg.sv ====
// Microarchitecture types for the MIPS core: ALU and memory operations and stage FSM states
`default_nettype none

package mipsCorePkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU,                 // Signed and unsigned compare
        ALU_SLL, ALU_SRL, ALU_SRA,         // opA shifted by opB[4:0]
        ALU_LUI                            // opB low half moved up
    } aluOp_t;

    typedef enum logic [1:0] {
        MEM_NONE, MEM_LOAD, MEM_STORE
    } memOp_t;

    // Fetch side of the req/ack handshake
    typedef enum logic [1:0] {
        FETCH_IDLE, FETCH_REQ, FETCH_HALTED
    } fetchState_t;

    // Bus owner in the memory access stage
    typedef enum logic [1:0] {
        MST_IDLE, MST_FETCH, MST_DATA, MST_RELEASE
    } memState_t;

endpackage

`default_nettype wire

// ==== fetchStage.sv ====
// Fetch stage that holds the PC, requests instruction words over the handshake and detects halt
`default_nettype none
`timescale 1ns/1ps

`include "mips_defines.svh"

module fetchStage (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              retire,     // Current instruction done
    input  wire mipsIsaPkg::word_t nextPc,
    input  wire logic              fetchAck,
    input  wire mipsIsaPkg::word_t fetchData,
    output logic                   fetchReq,
    output mipsIsaPkg::word_t      fetchAddr,
    output logic                   instrValid, // One-cycle pulse
    output mipsIsaPkg::word_t      instr,
    output mipsIsaPkg::word_t      pc,
    output logic                   active
);
    import mipsIsaPkg::*;
    import mipsCorePkg::*;

    fetchState_t state;

    assign fetchReq  = (state == FETCH_REQ);
    assign fetchAddr = pc;                    // Stable since pc only moves on retire

    always_ff @(posedge clk) begin
        instrValid <= 1'b0;
        if (reset) begin
            state  <= FETCH_REQ;              // Boot fetch goes out right after reset
            pc     <= `MIPS_RESET_PC;
            active <= 1'b1;
        end else begin
            case (state)
                FETCH_REQ: begin
                    if (fetchAck) begin
                        instr      <= fetchData;
                        instrValid <= 1'b1;
                        state      <= FETCH_IDLE; // Dropping req completes the handshake
                    end
                end
                FETCH_IDLE: begin
                    if (retire) begin
                        pc <= nextPc;
                        if (nextPc == `MIPS_HALT_PC) begin
                            state  <= FETCH_HALTED;
                            active <= 1'b0;
                        end else begin
                            state <= FETCH_REQ;
                        end
                    end
                end
                default: state <= FETCH_HALTED;   // Parked until reset
            endcase
        end
    end

    // New request only once the previous ack is gone
    assert property (@(posedge clk) disable iff (reset) $rose(fetchReq) |-> !fetchAck);

endmodule

`default_nettype wire

// ==== decodeStage.sv ====
// Decode stage between fetch and execute with the register file and operand/control selection
`default_nettype none
`timescale 1ns/1ps

`include "mips_defines.svh"

module decodeStage (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 instrValid,
    input  wire mipsIsaPkg::word_t    instr,
    input  wire mipsIsaPkg::word_t    pc,
    input  wire logic                 wbEnable,
    input  wire mipsIsaPkg::regAddr_t wbReg,
    input  wire mipsIsaPkg::word_t    wbData,
    output logic                      decValid,
    output mipsCorePkg::aluOp_t       aluOp,
    output mipsIsaPkg::word_t         opA,
    output mipsIsaPkg::word_t         opB,
    output mipsIsaPkg::word_t         storeData,
    output mipsIsaPkg::regAddr_t      destReg,
    output mipsCorePkg::memOp_t       memOp,
    output logic                      isBranchEq,
    output logic                      isBranchNe,
    output logic                      isJump,
    output logic                      isJumpReg,
    output mipsIsaPkg::imm_t          imm,
    output mipsIsaPkg::jumpTarget_t   jumpTarget,
    output mipsIsaPkg::word_t         pcOut,
    output mipsIsaPkg::word_t         registerV0
);
    import mipsIsaPkg::*;
    import mipsCorePkg::*;

    word_t    regs [`MIPS_REG_COUNT];
    opcode_t  opcode;
    funct_t   funct;
    regAddr_t rs, rt, rd;
    shamt_t   shamt;
    imm_t     immField;
    word_t    rsVal, rtVal, sExt, zExt;
    aluOp_t   dAluOp;
    word_t    dOpA, dOpB;
    regAddr_t dDest;
    memOp_t   dMemOp;
    logic     dBeq, dBne, dJump, dJumpReg;

    // Field split
    assign opcode   = opcode_t'(instr[31:26]);
    assign rs       = instr[25:21];
    assign rt       = instr[20:16];
    assign rd       = instr[15:11];
    assign shamt    = instr[10:6];
    assign funct    = funct_t'(instr[5:0]);
    assign immField = instr[15:0];

    assign rsVal = regs[rs];
    assign rtVal = regs[rt];
    assign sExt  = {{16{immField[15]}}, immField};
    assign zExt  = {16'h0000, immField};
    assign registerV0 = regs[2];

    always_comb begin
        dAluOp   = ALU_ADD;
        dOpA     = rsVal;
        dOpB     = (opcode == OP_SPECIAL) ? rtVal : sExt;
        dDest    = '0;                           // No writeback unless set below
        dMemOp   = MEM_NONE;
        dBeq     = 1'b0;
        dBne     = 1'b0;
        dJump    = 1'b0;
        dJumpReg = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                dDest = rd;
                case (funct)
                    FN_ADDU: dAluOp = ALU_ADD;
                    FN_SUBU: dAluOp = ALU_SUB;
                    FN_AND:  dAluOp = ALU_AND;
                    FN_OR:   dAluOp = ALU_OR;
                    FN_XOR:  dAluOp = ALU_XOR;
                    FN_SLT:  dAluOp = ALU_SLT;
                    FN_SLTU: dAluOp = ALU_SLTU;
                    FN_SLL, FN_SRL, FN_SRA: begin
                        dOpA   = rtVal;               // Shift rt by shamt
                        dOpB   = word_t'(shamt);
                        dAluOp = (funct == FN_SLL) ? ALU_SLL :
                                 (funct == FN_SRL) ? ALU_SRL : ALU_SRA;
                    end
                    FN_JR: begin
                        dJumpReg = 1'b1;
                        dDest    = '0;
                    end
                    default: dDest = '0;              // Unknown funct decodes as no-op
                endcase
            end
            OP_ADDIU: dDest = rt;
            OP_SLTI: begin
                dAluOp = ALU_SLT;
                dDest  = rt;
            end
            OP_SLTIU: begin
                dAluOp = ALU_SLTU;
                dDest  = rt;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                dOpB   = zExt;                        // Logical immediates zero-extend
                dDest  = rt;
                dAluOp = (opcode == OP_ANDI) ? ALU_AND :
                         (opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
            end
            OP_LUI: begin
                dAluOp = ALU_LUI;
                dDest  = rt;
            end
            OP_LW: begin
                dMemOp = MEM_LOAD;
                dDest  = rt;
            end
            OP_SW:  dMemOp = MEM_STORE;
            OP_BEQ: dBeq = 1'b1;
            OP_BNE: dBne = 1'b1;
            OP_J:   dJump = 1'b1;
            default: dDest = '0;                      // Unknown opcode decodes as no-op
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decValid <= 1'b0;
        end else begin
            decValid <= instrValid;
        end
        if (instrValid) begin
            aluOp      <= dAluOp;
            opA        <= dOpA;
            opB        <= dOpB;
            storeData  <= rtVal;                      // SW data and branch compare
            destReg    <= dDest;
            memOp      <= dMemOp;
            isBranchEq <= dBeq;
            isBranchNe <= dBne;
            isJump     <= dJump;
            isJumpReg  <= dJumpReg;
            imm        <= immField;
            jumpTarget <= instr[25:0];
            pcOut      <= pc;
        end
    end

    // Writeback from memory access on retire
    always_ff @(posedge clk) begin
        if (reset) begin
            regs[0] <= '0;                            // $0 stays zero as its writes are dropped
        end else if (wbEnable && wbReg != '0) begin
            regs[wbReg] <= wbData;
        end
    end

    // $0 operand reaches execute as zero
    assert property (@(posedge clk) disable iff (reset)
        instrValid && rt == '0 |=> decValid && storeData == '0);

endmodule

`default_nettype wire

// ==== executeStage.sv ====
// Execute stage between decode and memory access with the ALU, branch compare and next-PC logic
`default_nettype none
`timescale 1ns/1ps

module executeStage (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    decValid,
    input  wire mipsCorePkg::aluOp_t     aluOp,
    input  wire mipsIsaPkg::word_t       opA,
    input  wire mipsIsaPkg::word_t       opB,
    input  wire mipsIsaPkg::word_t       storeData,
    input  wire mipsIsaPkg::regAddr_t    destReg,
    input  wire mipsCorePkg::memOp_t     memOp,
    input  wire logic                    isBranchEq,
    input  wire logic                    isBranchNe,
    input  wire logic                    isJump,
    input  wire logic                    isJumpReg,
    input  wire mipsIsaPkg::imm_t        imm,
    input  wire mipsIsaPkg::jumpTarget_t jumpTarget,
    input  wire mipsIsaPkg::word_t       pc,
    output logic                         exValid,
    output mipsIsaPkg::word_t            aluResult,
    output mipsIsaPkg::word_t            exStoreData,
    output mipsIsaPkg::regAddr_t         exDestReg,
    output mipsCorePkg::memOp_t          exMemOp,
    output mipsIsaPkg::word_t            nextPc
);
    import mipsIsaPkg::*;
    import mipsCorePkg::*;

    word_t alu, pcPlus4, branchTarget, target;
    logic  branchTaken;

    always_comb begin
        case (aluOp)
            ALU_ADD:  alu = opA + opB;             // Also load/store address
            ALU_SUB:  alu = opA - opB;
            ALU_AND:  alu = opA & opB;
            ALU_OR:   alu = opA | opB;
            ALU_XOR:  alu = opA ^ opB;
            ALU_SLT:  alu = word_t'($signed(opA) < $signed(opB));
            ALU_SLTU: alu = word_t'(opA < opB);
            ALU_SLL:  alu = opA << opB[4:0];
            ALU_SRL:  alu = opA >> opB[4:0];
            ALU_SRA:  alu = word_t'($signed(opA) >>> opB[4:0]);
            ALU_LUI:  alu = {opB[15:0], 16'h0000};
            default:  alu = '0;
        endcase
    end

    // No delay slot so a taken branch goes straight to its target
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{imm[15]}}, imm, 2'b00};
    assign branchTaken  = (isBranchEq && opA == storeData) || (isBranchNe && opA != storeData);

    always_comb begin
        target = pcPlus4;
        if (isJumpReg) begin
            target = opA;
        end else if (isJump) begin
            target = {pcPlus4[31:28], jumpTarget, 2'b00};   // Same 256 MB region
        end else if (branchTaken) begin
            target = branchTarget;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exValid <= 1'b0;
        end else begin
            exValid <= decValid;
        end
        if (decValid) begin
            aluResult   <= alu;
            exStoreData <= storeData;
            exDestReg   <= destReg;
            exMemOp     <= memOp;
            nextPc      <= target;
        end
    end

endmodule

`default_nettype wire

// ==== memAccessStage.sv ====
// Memory access stage owning the Avalon master for fetches, LW and SW and driving writeback
`default_nettype none
`timescale 1ns/1ps

module memAccessStage (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 exValid,
    input  wire mipsIsaPkg::word_t    aluResult,
    input  wire mipsIsaPkg::word_t    storeData,
    input  wire mipsIsaPkg::regAddr_t destReg,
    input  wire mipsCorePkg::memOp_t  memOp,
    input  wire logic                 fetchReq,
    input  wire mipsIsaPkg::word_t    fetchAddr,
    input  wire logic                 waitrequest,
    input  wire mipsIsaPkg::word_t    readdata,
    output logic                      fetchAck,
    output mipsIsaPkg::word_t         fetchData,
    output logic                      retire,     // One-cycle pulse with writeback
    output logic                      wbEnable,
    output mipsIsaPkg::regAddr_t      wbReg,
    output mipsIsaPkg::word_t         wbData,
    output mipsIsaPkg::word_t         address,
    output logic                      read,
    output logic                      write,
    output mipsIsaPkg::word_t         writedata,
    output logic [3:0]                byteenable
);
    import mipsIsaPkg::*;
    import mipsCorePkg::*;

    memState_t state;

    assign byteenable = 4'hF;                      // Word accesses only

    always_ff @(posedge clk) begin
        retire   <= 1'b0;
        wbEnable <= 1'b0;
        if (reset) begin
            state    <= MST_IDLE;
            read     <= 1'b0;
            write    <= 1'b0;
            fetchAck <= 1'b0;
        end else begin
            case (state)
                MST_IDLE: begin
                    if (exValid) begin
                        wbReg  <= destReg;
                        wbData <= aluResult;
                        if (memOp == MEM_NONE) begin
                            retire   <= 1'b1;      // ALU result retires next cycle
                            wbEnable <= 1'b1;      // Jumps carry $0 which decode drops
                        end else begin
                            address   <= {aluResult[31:2], 2'b00};
                            writedata <= storeData;
                            read      <= (memOp == MEM_LOAD);
                            write     <= (memOp == MEM_STORE);
                            state     <= MST_DATA;
                        end
                    end else if (fetchReq) begin
                        address <= fetchAddr;      // Instruction address straight from the PC
                        read    <= 1'b1;
                        state   <= MST_FETCH;
                    end
                end
                MST_FETCH: begin
                    if (!waitrequest) begin
                        read      <= 1'b0;
                        fetchData <= readdata;
                        fetchAck  <= 1'b1;
                        state     <= MST_RELEASE;
                    end
                end
                MST_RELEASE: begin
                    if (!fetchReq) begin           // Four-phase handshake waits for req to drop
                        fetchAck <= 1'b0;
                        state    <= MST_IDLE;
                    end
                end
                MST_DATA: begin
                    if (!waitrequest) begin
                        read     <= 1'b0;
                        write    <= 1'b0;
                        retire   <= 1'b1;
                        wbEnable <= read;          // Only LW writes back
                        if (read) begin
                            wbData <= readdata;
                        end
                        state <= MST_IDLE;
                    end
                end
                default: state <= MST_IDLE;
            endcase
        end
    end

    // Avalon master rules
    assert property (@(posedge clk) disable iff (reset) !(read && write));
    assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(read) && $stable(write));
    assert property (@(posedge clk) disable iff (reset) (read || write) |-> address[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== mipsCpuBus.sv ====
// Top of the multi-cycle MIPS core; chains fetch, decode, execute and memory access to Avalon
`default_nettype none
`timescale 1ns/1ps

module mipsCpuBus (
    input  wire logic               clk,
    input  wire logic               reset,
    output logic                    active,
    output mipsIsaPkg::word_t       registerV0,
    output mipsIsaPkg::word_t       address,
    output logic                    read,
    output logic                    write,
    input  wire logic               waitrequest,
    output mipsIsaPkg::word_t       writedata,
    output logic [3:0]              byteenable,
    input  wire mipsIsaPkg::word_t  readdata
);
    import mipsIsaPkg::*;
    import mipsCorePkg::*;

    // Fetch <-> memory access handshake
    logic        fetchReq, fetchAck;
    word_t       fetchAddr, fetchData;
    // Fetch -> decode
    logic        instrValid;
    word_t       instr, pc;
    // Decode -> execute
    logic        decValid, isBranchEq, isBranchNe, isJump, isJumpReg;
    aluOp_t      aluOp;
    word_t       opA, opB, decStoreData, decPc;
    regAddr_t    decDestReg;
    memOp_t      decMemOp;
    imm_t        imm;
    jumpTarget_t jumpTarget;
    // Execute -> memory access and fetch
    logic        exValid;
    word_t       aluResult, exStoreData, nextPc;
    regAddr_t    exDestReg;
    memOp_t      exMemOp;
    // Retire and writeback
    logic        retire, wbEnable;
    regAddr_t    wbReg;
    word_t       wbData;

    fetchStage u_fetch (
        .clk(clk), .reset(reset), .retire(retire), .nextPc(nextPc),
        .fetchAck(fetchAck), .fetchData(fetchData), .fetchReq(fetchReq),
        .fetchAddr(fetchAddr), .instrValid(instrValid), .instr(instr), .pc(pc),
        .active(active)
    );

    decodeStage u_decode (
        .clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr), .pc(pc),
        .wbEnable(wbEnable), .wbReg(wbReg), .wbData(wbData),
        .decValid(decValid), .aluOp(aluOp), .opA(opA), .opB(opB),
        .storeData(decStoreData), .destReg(decDestReg), .memOp(decMemOp),
        .isBranchEq(isBranchEq), .isBranchNe(isBranchNe), .isJump(isJump),
        .isJumpReg(isJumpReg), .imm(imm), .jumpTarget(jumpTarget), .pcOut(decPc),
        .registerV0(registerV0)
    );

    executeStage u_execute (
        .clk(clk), .reset(reset), .decValid(decValid), .aluOp(aluOp), .opA(opA), .opB(opB),
        .storeData(decStoreData), .destReg(decDestReg), .memOp(decMemOp),
        .isBranchEq(isBranchEq), .isBranchNe(isBranchNe), .isJump(isJump),
        .isJumpReg(isJumpReg), .imm(imm), .jumpTarget(jumpTarget), .pc(decPc),
        .exValid(exValid), .aluResult(aluResult), .exStoreData(exStoreData),
        .exDestReg(exDestReg), .exMemOp(exMemOp), .nextPc(nextPc)
    );

    memAccessStage u_mem (
        .clk(clk), .reset(reset), .exValid(exValid), .aluResult(aluResult),
        .storeData(exStoreData), .destReg(exDestReg), .memOp(exMemOp),
        .fetchReq(fetchReq), .fetchAddr(fetchAddr), .waitrequest(waitrequest),
        .readdata(readdata), .fetchAck(fetchAck), .fetchData(fetchData),
        .retire(retire), .wbEnable(wbEnable), .wbReg(wbReg), .wbData(wbData),
        .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable)
    );

endmodule

`default_nettype wire

// ==== tbAvalonMem.sv ====
// Behavioral Avalon slave for the testbench; 1 KB of memory at the reset vector with random stalls
`default_nettype none
`timescale 1ns/1ps

`include "mips_defines.svh"

module tbAvalonMem (
    input  wire logic              clk,
    input  wire mipsIsaPkg::word_t address,
    input  wire logic              read,
    input  wire logic              write,
    input  wire mipsIsaPkg::word_t writedata,
    output logic                   waitrequest,
    output mipsIsaPkg::word_t      readdata
);
    import mipsIsaPkg::*;

    localparam int    DEPTH = 256;              // Words in the window
    localparam word_t BASE  = `MIPS_RESET_PC;

    word_t      mem [DEPTH];
    integer     seed;
    logic       inWindow;
    logic [7:0] index;

    // Pattern for words never loaded or written
    function automatic word_t fillWord(input word_t addr);
        return addr ^ 32'hA5C3_5A3C;
    endfunction

    assign inWindow = (address[31:10] == BASE[31:10]);
    assign index    = address[9:2];

    initial begin
        seed        = 32'h20168ae3;
        waitrequest = 1'b1;                     // Stalled until the first falling edge
        readdata    = '0;
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = fillWord(BASE + word_t'(i) * 32'd4);
        end
        $readmemh("program.hex", mem);          // Program from the boot vector up
    end

    // Slave outputs change on the falling edge only
    always @(negedge clk) begin
        waitrequest = (($random(seed) & 7) < 3);   // Roughly 3 stalls in 8
        readdata    = inWindow ? mem[index] : fillWord(address);
    end

    // Write lands in the cycle the master sees waitrequest low
    always @(posedge clk) begin
        if (write && !waitrequest && inWindow) begin
            mem[index] = writedata;
        end
    end

endmodule

`default_nettype wire

// ==== tbMipsCpuBus.sv ====
// Testbench top for the MIPS core; runs program.hex and checks bus rules, stores and halt
`default_nettype none
`timescale 1ns/1ps

`include "mips_defines.svh"

module tbMipsCpuBus;
    import mipsIsaPkg::*;

    localparam word_t DATA_BASE = 32'hBFC00200;  // $29 in the program
    localparam word_t EXP_V0    = 32'h0FFF00FC;  // (lw result + andi result) ^ srl result

    logic       clk = 1'b0;
    logic       reset;
    logic       active, read, write, waitrequest;
    logic [3:0] byteenable;
    word_t      registerV0, address, writedata, readdata;
    word_t      expAddr [64];
    word_t      expData [64];
    logic [5:0] expCount, storeIdx;
    logic       seenRead, stallSeen;

    mipsCpuBus u_dut (
        .clk(clk), .reset(reset), .active(active), .registerV0(registerV0),
        .address(address), .read(read), .write(write), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    tbAvalonMem u_mem (
        .clk(clk), .address(address), .read(read), .write(write),
        .writedata(writedata), .waitrequest(waitrequest), .readdata(readdata)
    );

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic reportMismatch(input string name, input word_t expected, input word_t actual);
        abortRun($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic expectStore(input word_t offset, input word_t data);
        expAddr[expCount] = DATA_BASE + offset;
        expData[expCount] = data;
        expCount          = expCount + 6'd1;
    endtask

    initial begin
        forever #4 clk = ~clk;
    end

    // Progress markers for the assertions below
    always @(posedge clk) begin
        if (reset) begin
            storeIdx  <= '0;
            seenRead  <= 1'b0;
            stallSeen <= 1'b0;
        end else begin
            if (write && !waitrequest) storeIdx <= storeIdx + 6'd1;
            if (read) seenRead <= 1'b1;
            if ((read || write) && waitrequest) stallSeen <= 1'b1;
        end
    end

    // Boot fetch
    assert property (@(posedge clk) disable iff (reset)
        read && !seenRead |-> address == `MIPS_RESET_PC)
        else reportMismatch("address", `MIPS_RESET_PC, $sampled(address));
    assert property (@(posedge clk) disable iff (reset) read && !seenRead |-> active)
        else abortRun("core was not active at the first fetch");

    // Avalon master rules
    assert property (@(posedge clk) disable iff (reset) !(read && write))
        else abortRun("read and write were high together");
    assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(read) && $stable(write))
        else abortRun("bus request changed while waitrequest was high");
    assert property (@(posedge clk) disable iff (reset) write && waitrequest |=> $stable(writedata))
        else abortRun("writedata changed while waitrequest was high");
    assert property (@(posedge clk) disable iff (reset) (read || write) |-> address[1:0] == 2'b00)
        else abortRun("bus address was not word aligned");
    assert property (@(posedge clk) disable iff (reset) (read || write) |-> byteenable == 4'hF)
        else reportMismatch("byteenable", 32'hF, {28'h0, $sampled(byteenable)});

    // Completed writes in program order with skipped stores absent
    assert property (@(posedge clk) disable iff (reset) write && !waitrequest |-> storeIdx < expCount)
        else abortRun("more stores than expected, a skipped store was executed");
    assert property (@(posedge clk) disable iff (reset)
        write && !waitrequest && storeIdx < expCount |-> address == expAddr[storeIdx])
        else reportMismatch("address", expAddr[$sampled(storeIdx)], $sampled(address));
    assert property (@(posedge clk) disable iff (reset)
        write && !waitrequest && storeIdx < expCount |-> writedata == expData[storeIdx])
        else reportMismatch("writedata", expData[$sampled(storeIdx)], $sampled(writedata));

    // Halted core stays off the bus
    assert property (@(posedge clk) disable iff (reset) !active |-> !read && !write)
        else abortRun("bus access after the core halted");

    initial begin
        int cycles;
        reset    = 1'b1;
        expCount = '0;
        expectStore(32'h00, 32'hBFC00200);   // lui + ori base
        expectStore(32'h04, 32'hFFFFFFF8);   // addiu sign-extends -8
        expectStore(32'h08, 32'h0000000B);   // addu
        expectStore(32'h0C, 32'h0000001B);   // subu
        expectStore(32'h10, 32'h00000010);   // and
        expectStore(32'h14, 32'hFFFFFFFB);   // or
        expectStore(32'h18, 32'hFFFFFFEB);   // xor
        expectStore(32'h1C, 32'h00000001);   // slt with -8 < 19
        expectStore(32'h20, 32'h00000000);   // sltu of huge vs 19
        expectStore(32'h24, 32'hFFFFFF80);   // sll 4
        expectStore(32'h28, 32'h0FFFFFFF);   // srl 4
        expectStore(32'h2C, 32'hFFFFFFFF);   // sra 4
        expectStore(32'h30, 32'h0000FF08);   // andi zero-extends
        expectStore(32'h34, 32'hFFFF7FF9);   // xori zero-extends
        expectStore(32'h38, 32'h00000001);   // slti
        expectStore(32'h3C, 32'h00000001);   // sltiu against sign-extended 0xFFFF
        expectStore(32'h40, 32'h80010000);   // lui
        expectStore(32'h44, 32'h00000000);   // $0 after a write to it
        expectStore(32'h48, 32'hFFFFFFFB);   // lw of the or result stored again
        expectStore(32'h4C, 32'h00000013);   // after untaken beq only
        expectStore(32'h50, 32'h0000000B);   // after untaken bne only
        expectStore(32'h54, EXP_V0);         // Checksum after j skipped the store before it
        repeat (2) @(negedge clk);
        reset = 1'b0;

        cycles = 0;
        while (!read) begin
            @(negedge clk);
            cycles++;
            if (cycles > 100) begin
                abortRun("timeout waiting for the first bus read");
            end
        end

        // jr $0 ends the program
        cycles = 0;
        while (active) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20000) begin
                abortRun("timeout waiting for the core to halt");
            end
        end
        assert (registerV0 == EXP_V0)
            else reportMismatch("registerV0", EXP_V0, registerV0);

        for (int i = 0; i < 20; i++) begin
            @(negedge clk);                  // Quiet window watched by the halt assertion
        end

        if (storeIdx != expCount || !stallSeen) begin
            abortRun($sformatf("run incomplete, %0d of %0d stores seen, stall seen %0b",
                               storeIdx, expCount, stallSeen));
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== mipsBus.f ====
+incdir+.
mipsIsaPkg.sv
mipsCorePkg.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memAccessStage.sv
mipsCpuBus.sv
tbAvalonMem.sv
tbMipsCpuBus.sv

// ==== Makefile ====
# Verilator flow for the MIPS core testbench, override any variable on the command line
VERILATOR ?= verilator
TOP       ?= tbMipsCpuBus
FILELIST  ?= mipsBus.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

# Output goes to the terminal, the pass line decides the exit status
run: build
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep "$(PASS_TEXT)" > /dev/null

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== program.hex ====
// Instruction words in execution order from 0xBFC00000, several per line
// $29 points at the data area 0xBFC00200, $8 = -8 and $9 = 0x13 are the constants
3C1DBFC0 37BD0200 AFBD0000            // lui/ori $29, store it
2408FFF8 AFA80004 24090013            // addiu $8 stored, addiu $9
01095821 AFAB0008 01286023 AFAC000C   // addu, subu
01096824 AFAD0010 01097025 AFAE0014   // and, or
01097826 AFAF0018 0109802A AFB0001C   // xor, slt
0109882B AFB10020 00089100 AFB20024   // sltu, sll
00089902 AFB30028 0008A103 AFB4002C   // srl, sra
3115FF0F AFB50030 39168001 AFB60034   // andi, xori
2917FFF9 AFB70038 2D38FFFF AFB8003C   // slti, sltiu
3C0A8001 AFAA0040 24000055 AFA00044   // lui, write $0 then store $0
8FB90014 AFB90048                     // lw the or result, store again
11080001 AFA8004C 11090001 AFA9004C   // beq taken skips, beq untaken
15090001 AFA80050 15080001 AFAB0050   // bne taken skips, bne untaken
0BF00032 AFA80054                     // j over a store
03351021 00531026 AFA20054 00000008   // checksum in $2, jr $0 halts
